//--- verilog.f
+incdir+include
rtl/ex_pkg.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_top.sv
verif/ex_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module ex_tb -o ex_tb_sim
./obj_dir/ex_tb_sim

//--- include/ex_tb_vectors.svh
// wr  inst, pc, rs1, rs2, rd, data        br  inst, pc, rs1, rs2, taken, target
// jp  inst, pc, rs1, rd, target           rand_row  funct7, funct3, rd
task automatic load_vectors();
    // register-register
    wr(enc_r(7'h00, f3_add, 5'd3), 32'h100, 32'd5, 32'd7, 5'd3, 32'd12);
    wr(enc_r(7'h20, f3_add, 5'd4), 32'h104, 32'd5, 32'd7, 5'd4, 32'hFFFFFFFE);
    wr(enc_r(7'h00, f3_sr, 5'd5), 32'h108, 32'h80000010, 32'd4, 5'd5, 32'h08000001);
    wr(enc_r(7'h20, f3_sr, 5'd6), 32'h10C, 32'h80000010, 32'd4, 5'd6, 32'hF8000001);
    wr(enc_r(7'h00, f3_slt, 5'd7), 32'h110, 32'hFFFFFFFF, 32'd1, 5'd7, 32'd1);
    wr(enc_r(7'h00, f3_sltu, 5'd8), 32'h114, 32'hFFFFFFFF, 32'd1, 5'd8, 32'd0);
    wr(enc_r(7'h00, f3_sll, 5'd9), 32'h118, 32'd3, 32'h21, 5'd9, 32'd6);
    wr(enc_r(7'h00, f3_xor, 5'd10), 32'h11C, 32'hF0F0F0F0, 32'h0FF00FF0, 5'd10, 32'hFF00FF00);
    wr(enc_r(7'h00, f3_or, 5'd11), 32'h120, 32'hF0F0F0F0, 32'h0FF00FF0, 5'd11, 32'hFFF0FFF0);
    wr(enc_r(7'h00, f3_and, 5'd12), 32'h124, 32'hF0F0F0F0, 32'h0FF00FF0, 5'd12, 32'h00F000F0);
    idle_row();
    // immediate forms, rs2 must be ignored
    wr(enc_i(op_imm, f3_add, 5'd13, 12'hFFB), 32'h200, 32'd10, 32'hDEADBEEF, 5'd13, 32'd5);
    wr(enc_i(op_imm, f3_slt, 5'd14, 12'hFFF), 32'h204, 32'hFFFFFFFE, 32'd0, 5'd14, 32'd1);
    wr(enc_i(op_imm, f3_sltu, 5'd15, 12'hFFF), 32'h208, 32'd5, 32'd0, 5'd15, 32'd1);
    wr(enc_i(op_imm, f3_xor, 5'd16, 12'h7FF), 32'h20C, 32'h00000F00, 32'd0, 5'd16, 32'h000008FF);
    wr(enc_i(op_imm, f3_and, 5'd17, 12'h800), 32'h210, 32'h12345FFF, 32'd0, 5'd17, 32'h12345800);
    wr(enc_i(op_imm, f3_sr, 5'd18, {7'h20, 5'd8}), 32'h214, 32'h80000000, 32'd0, 5'd18,
       32'hFF800000);
    wr(enc_i(op_imm, f3_sr, 5'd19, {7'h00, 5'd8}), 32'h218, 32'h80000000, 32'd0, 5'd19,
       32'h00800000);
    wr(enc_i(op_imm, f3_sll, 5'd20, 12'd31), 32'h21C, 32'd1, 32'd0, 5'd20, 32'h80000000);
    wr(enc_u(op_lui, 5'd21, 20'hABCDE), 32'h220, 32'd0, 32'd0, 5'd21, 32'hABCDE000);
    wr(enc_u(op_auipc, 5'd22, 20'hFFFFF), 32'h2000, 32'd0, 32'd0, 5'd22, 32'h00001000);
    // each branch taken, then not taken
    br(enc_b(f3_beq, 13'h0010), 32'h1000, 32'd7, 32'd7, 1'b1, 32'h1010);
    br(enc_b(f3_beq, 13'h0010), 32'h1000, 32'd7, 32'd8, 1'b0, 32'h0);
    br(enc_b(f3_bne, 13'h1FF8), 32'h1000, 32'd7, 32'd8, 1'b1, 32'h0FF8);
    br(enc_b(f3_bne, 13'h1FF8), 32'h1000, 32'd7, 32'd7, 1'b0, 32'h0);
    br(enc_b(f3_blt, 13'h0020), 32'h1000, 32'hFFFFFFFF, 32'd1, 1'b1, 32'h1020);
    br(enc_b(f3_blt, 13'h0020), 32'h1000, 32'd1, 32'hFFFFFFFF, 1'b0, 32'h0);
    br(enc_b(f3_bge, 13'h0010), 32'h1000, 32'd1, 32'hFFFFFFFF, 1'b1, 32'h1010);
    br(enc_b(f3_bge, 13'h0010), 32'h1000, 32'hFFFFFFFF, 32'd1, 1'b0, 32'h0);
    br(enc_b(f3_bltu, 13'h0010), 32'h1000, 32'd1, 32'hFFFFFFFF, 1'b1, 32'h1010);
    br(enc_b(f3_bltu, 13'h0010), 32'h1000, 32'hFFFFFFFF, 32'd1, 1'b0, 32'h0);
    br(enc_b(f3_bgeu, 13'h1000), 32'h2000, 32'hFFFFFFFF, 32'd1, 1'b1, 32'h1000);
    br(enc_b(f3_bgeu, 13'h1000), 32'h2000, 32'd1, 32'hFFFFFFFF, 1'b0, 32'h0);
    // jal forward and backward, jalr drops bit 0
    jp(enc_j(5'd1, 21'h000800), 32'h3000, 32'd0, 5'd1, 32'h3800);
    jp(enc_j(5'd2, 21'h1FFF00), 32'h3000, 32'd0, 5'd2, 32'h2F00);
    jp(enc_i(op_jalr, 3'b000, 5'd3, 12'h005), 32'h500, 32'h4000, 5'd3, 32'h4004);
    jp(enc_i(op_jalr, 3'b000, 5'd4, 12'hFFD), 32'h600, 32'h4000, 5'd4, 32'h3FFC);
    // load opcode, bad branch funct3, bad jalr funct3
    nop_row(32'h00002003);
    nop_row(enc_b(3'b010, 13'h0010));
    nop_row(enc_i(op_jalr, 3'b001, 5'd5, 12'h0));
    idle_row();
    idle_row();
    rand_row(7'h00, f3_add, 5'd24);
    rand_row(7'h20, f3_add, 5'd25);
    rand_row(7'h20, f3_sr, 5'd26);
    rand_row(7'h00, f3_sr, 5'd27);
    rand_row(7'h00, f3_slt, 5'd28);
    rand_row(7'h00, f3_sltu, 5'd29);
    rand_row(7'h00, f3_sll, 5'd30);
endtask

//--- verif/ex_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ex_tb;

    import ex_pkg::*;

    typedef struct packed {
        logic     valid;
        word_t    inst;
        word_t    pc;
        word_t    rs1;
        word_t    rs2;
        ex_wb_t   wb;
        ex_jump_t jump;
    } vec_t;

    typedef struct packed {
        logic [31:0] due;
        ex_wb_t      wb;
        ex_jump_t    jump;
    } exp_t;

    logic      clk = 1'b0;
    logic      reset_i;
    ex_issue_t issue_i;
    ex_wb_t    wb_o;
    ex_jump_t  jump_o;

    vec_t   vecs[$];
    exp_t   exp_q[$];
    exp_t   new_exp;
    integer seed;
    int     cycle;
    int     wait_cnt;

    ex_top DUT (
        .clk     (clk),
        .reset_i (reset_i),
        .issue_i (issue_i),
        .wb_o    (wb_o),
        .jump_o  (jump_o)
    );

    always #5 clk = ~clk;

    initial begin
        reset_i = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
    end

    // encoders put x1 in the rs1 field and x2 in the rs2 field
    function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd);
        return {f7, 5'd2, 5'd1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_i(logic [6:0] op, logic [2:0] f3, reg_addr_t rd,
                                    logic [11:0] imm);
        return {imm, 5'd1, f3, rd, op};
    endfunction

    function automatic word_t enc_b(logic [2:0] f3, logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic word_t enc_j(reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic word_t enc_u(logic [6:0] op, reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    // rv32i register-register result
    function automatic word_t reg_op_ref(logic [6:0] f7, logic [2:0] f3, word_t a, word_t b);
        logic [4:0] sh;
        logic       lt;
        sh = b[4:0];
        lt = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            3'd0: return f7[5] ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'd0, lt};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return (f7[5] && a[31]) ? ~((~a) >> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_vec(logic valid, word_t inst, word_t pc, word_t rs1, word_t rs2,
                           ex_wb_t wb, ex_jump_t jump);
        vecs.push_back({valid, inst, pc, rs1, rs2, wb, jump});
    endtask

    task automatic wr(word_t inst, word_t pc, word_t rs1, word_t rs2, reg_addr_t rd,
                      word_t data);
        add_vec(1'b1, inst, pc, rs1, rs2, {1'b1, rd, data}, '0);
    endtask

    task automatic br(word_t inst, word_t pc, word_t rs1, word_t rs2, logic taken,
                      word_t addr);
        add_vec(1'b1, inst, pc, rs1, rs2, '0, {taken, addr});
    endtask

    // jal and jalr link to pc+4
    task automatic jp(word_t inst, word_t pc, word_t rs1, reg_addr_t rd, word_t addr);
        add_vec(1'b1, inst, pc, rs1, 32'd0, {1'b1, rd, pc + 32'd4}, {1'b1, addr});
    endtask

    task automatic nop_row(word_t inst);
        add_vec(1'b1, inst, 32'h700, 32'h5, 32'h5, '0, '0);
    endtask

    // valid low hides a jal that would otherwise write and jump
    task automatic idle_row();
        add_vec(1'b0, enc_j(5'd1, 21'h000800), 32'h3000, 32'd0, 32'd0, '0, '0);
    endtask

    task automatic rand_row(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd);
        word_t a;
        word_t b;
        a = $random(seed);
        b = $random(seed);
        wr(enc_r(f7, f3, rd), 32'h400, a, b, rd, reg_op_ref(f7, f3, a, b));
    endtask

    `include "ex_tb_vectors.svh"

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(string name, word_t exp, word_t act);
        abort_run($sformatf("FAILED at %0t: %s expected 0x%h, got 0x%h",
                            $time, name, exp, act));
    endtask

    // rd and data only matter when a write is expected
    task automatic check_wb(ex_wb_t exp, ex_wb_t act);
        if (act.we !== exp.we) begin
            value_error("wb_o.we", word_t'(exp.we), word_t'(act.we));
        end else if (exp.we && act.rd !== exp.rd) begin
            value_error("wb_o.rd", word_t'(exp.rd), word_t'(act.rd));
        end else if (exp.we && act.data !== exp.data) begin
            value_error("wb_o.data", exp.data, act.data);
        end
    endtask

    task automatic check_jump(ex_jump_t exp, ex_jump_t act);
        if (act.flag !== exp.flag) begin
            value_error("jump_o.flag", word_t'(exp.flag), word_t'(act.flag));
        end else if (exp.flag && act.addr !== exp.addr) begin
            value_error("jump_o.addr", exp.addr, act.addr);
        end
    endtask

    task automatic check_due();
        exp_t e;
        if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            e = exp_q.pop_front();
            check_wb(e.wb, wb_o);
            check_jump(e.jump, jump_o);
        end
    endtask

    initial begin
        // a valid jal stays on the input through reset
        issue_i = {1'b1, 32'h3000, enc_j(5'd1, 21'h000800), 32'd0, 32'd0};
        seed = 15118;
        cycle = 0;
        load_vectors();
        @(posedge clk);
        wait_cnt = 0;
        while (reset_i) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 20) abort_run("reset was still asserted after 20 cycles");
        end
        @(negedge clk);
        check_wb('0, wb_o);
        check_jump('0, jump_o);
        issue_i = '0;
        // the held jal was taken on the first edge out of reset
        new_exp.due = cycle + 1;
        new_exp.wb = {1'b1, 5'd1, 32'h3000 + 32'd4};
        new_exp.jump = {1'b1, 32'h3000 + 32'h800};
        exp_q.push_back(new_exp);
        // one row per cycle back to back and checked two cycles later
        for (int i = 0; i < vecs.size(); i++) begin
            @(negedge clk);
            cycle++;
            check_due();
            issue_i = {vecs[i].valid, vecs[i].pc, vecs[i].inst, vecs[i].rs1, vecs[i].rs2};
            new_exp.due = cycle + 2;
            new_exp.wb = vecs[i].wb;
            new_exp.jump = vecs[i].jump;
            exp_q.push_back(new_exp);
        end
        wait_cnt = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            cycle++;
            check_due();
            issue_i = '0;
            wait_cnt++;
            if (wait_cnt > 10) abort_run("results still pending after 10 idle cycles");
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/ex_top.sv
`timescale 1ns/10ps
`default_nettype none

module ex_top (
    input  logic              clk,
    input  logic              reset_i,
    input  ex_pkg::ex_issue_t issue_i,
    output ex_pkg::ex_wb_t    wb_o,
    output ex_pkg::ex_jump_t  jump_o
);

    import ex_pkg::*;

    // registered decode result, one cycle behind issue
    ex_uop_t uop;

    ex_decode u_decode (
        .clk     (clk),
        .reset_i (reset_i),
        .issue_i (issue_i),
        .uop_o   (uop)
    );

    // results land two edges after issue
    ex_alu u_alu (
        .clk     (clk),
        .reset_i (reset_i),
        .uop_i   (uop),
        .wb_o    (wb_o),
        .jump_o  (jump_o)
    );

endmodule

`default_nettype wire

//--- rtl/ex_alu.sv
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
    input  logic             clk,
    input  logic             reset_i,
    input  ex_pkg::ex_uop_t  uop_i,
    output ex_pkg::ex_wb_t   wb_o,
    output ex_pkg::ex_jump_t jump_o
);

    import ex_pkg::*;

    logic [shamt_w-1:0] shamt;
    logic               a_lt_b;
    logic               a_ltu_b;
    logic               do_write;
    logic               take_jump;
    word_t              result;
    word_t              target;
    word_t              link;
    word_t              pc_target;
    ex_wb_t             wb_d;
    ex_jump_t           jump_d;

    assign shamt     = uop_i.b[shamt_w-1:0];
    assign a_lt_b    = $signed(uop_i.a) < $signed(uop_i.b);
    assign a_ltu_b   = uop_i.a < uop_i.b;
    assign link      = uop_i.pc + word_t'(4);
    assign pc_target = uop_i.pc + uop_i.imm;

    always_comb begin
        result    = '0;
        do_write  = 1'b1;
        take_jump = 1'b0;
        target    = pc_target;
        case (uop_i.op)
            alu_add:    result = uop_i.a + uop_i.b;
            alu_sub:    result = uop_i.a - uop_i.b;
            alu_sll:    result = uop_i.a << shamt;
            alu_srl:    result = uop_i.a >> shamt;
            alu_sra:    result = word_t'($signed(uop_i.a) >>> shamt);
            alu_slt:    result = {{(xlen-1){1'b0}}, a_lt_b};
            alu_sltu:   result = {{(xlen-1){1'b0}}, a_ltu_b};
            alu_xor:    result = uop_i.a ^ uop_i.b;
            alu_or:     result = uop_i.a | uop_i.b;
            alu_and:    result = uop_i.a & uop_i.b;
            alu_pass_b: result = uop_i.b;
            alu_beq: begin
                do_write  = 1'b0;
                take_jump = (uop_i.a == uop_i.b);
            end
            alu_bne: begin
                do_write  = 1'b0;
                take_jump = (uop_i.a != uop_i.b);
            end
            alu_blt: begin
                do_write  = 1'b0;
                take_jump = a_lt_b;
            end
            alu_bge: begin
                do_write  = 1'b0;
                take_jump = !a_lt_b;
            end
            alu_bltu: begin
                do_write  = 1'b0;
                take_jump = a_ltu_b;
            end
            alu_bgeu: begin
                do_write  = 1'b0;
                take_jump = !a_ltu_b;
            end
            alu_jal: begin
                result    = link;
                take_jump = 1'b1;
            end
            alu_jalr: begin
                // rs1 based, low bit dropped
                result    = link;
                take_jump = 1'b1;
                target    = (uop_i.a + uop_i.imm) & ~word_t'(1);
            end
            default: begin
                do_write = 1'b0;
            end
        endcase
    end

    // inactive records go out as all zero
    always_comb begin
        wb_d.we     = uop_i.valid && do_write;
        wb_d.rd     = wb_d.we ? uop_i.rd : '0;
        wb_d.data   = wb_d.we ? result : '0;
        jump_d.flag = uop_i.valid && take_jump;
        jump_d.addr = jump_d.flag ? target : '0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o   <= '0;
            jump_o <= '0;
        end else begin
            wb_o   <= wb_d;
            jump_o <= jump_d;
        end
    end

    // relies on the decoder clearing bit 0 of branch and jal offsets
    a_even_target: assert property (
        @(posedge clk) disable iff (reset_i)
        uop_i.valid && take_jump |=> jump_o.flag && !jump_o.addr[0]
    );

    a_write_and_jump: assert property (
        @(posedge clk) disable iff (reset_i)
        wb_o.we && jump_o.flag |-> $past(uop_i.op) inside {alu_jal, alu_jalr}
    );

endmodule

`default_nettype wire

//--- rtl/ex_decode.sv
`timescale 1ns/10ps
`default_nettype none

module ex_decode (
    input  logic              clk,
    input  logic              reset_i,
    input  ex_pkg::ex_issue_t issue_i,
    output ex_pkg::ex_uop_t   uop_o
);

    import ex_pkg::*;

    rv_inst_u inst;
    word_t    imm_i;
    word_t    imm_b;
    word_t    imm_j;
    word_t    imm_u;
    ex_uop_t  uop_d;

    // shared by op_reg and op_imm, sub only exists in register form
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
        alu_op_e op;
        case (f3)
            f3_add:  op = (alt && is_reg) ? alu_sub : alu_add;
            f3_sll:  op = alu_sll;
            f3_slt:  op = alu_slt;
            f3_sltu: op = alu_sltu;
            f3_xor:  op = alu_xor;
            f3_sr:   op = alt ? alu_sra : alu_srl;
            f3_or:   op = alu_or;
            f3_and:  op = alu_and;
            default: op = alu_none;
        endcase
        return op;
    endfunction

    function automatic alu_op_e branch_op(input logic [2:0] f3);
        alu_op_e op;
        case (f3)
            f3_beq:  op = alu_beq;
            f3_bne:  op = alu_bne;
            f3_blt:  op = alu_blt;
            f3_bge:  op = alu_bge;
            f3_bltu: op = alu_bltu;
            f3_bgeu: op = alu_bgeu;
            default: op = alu_none;
        endcase
        return op;
    endfunction

    assign inst = issue_i.inst;

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_b = {{20{inst.r_fmt.funct7[6]}}, inst.r_fmt.rd[0],
                    inst.r_fmt.funct7[5:0], inst.r_fmt.rd[4:1], 1'b0};
    assign imm_j = {{12{inst.i_fmt.imm[11]}}, inst.i_fmt.rs1, inst.i_fmt.funct3,
                    inst.i_fmt.imm[0], inst.i_fmt.imm[10:1], 1'b0};
    assign imm_u = {inst.i_fmt.imm, inst.i_fmt.rs1, inst.i_fmt.funct3, 12'b0};

    always_comb begin
        uop_d.valid = issue_i.valid;
        uop_d.op    = alu_none;
        uop_d.rd    = inst.r_fmt.rd;
        uop_d.a     = issue_i.rs1_data;
        uop_d.b     = issue_i.rs2_data;
        uop_d.pc    = issue_i.pc;
        uop_d.imm   = imm_i;
        case (inst.r_fmt.opcode)
            op_reg: begin
                uop_d.op = arith_op(inst.r_fmt.funct3, inst.r_fmt.funct7[5], 1'b1);
            end
            op_imm: begin
                // bit 30 selects srai over srli
                uop_d.op = arith_op(inst.i_fmt.funct3, inst.r_fmt.funct7[5], 1'b0);
                uop_d.b  = imm_i;
            end
            op_branch: begin
                uop_d.op  = branch_op(inst.r_fmt.funct3);
                uop_d.imm = imm_b;
            end
            op_jal: begin
                uop_d.op  = alu_jal;
                uop_d.imm = imm_j;
            end
            op_jalr: begin
                if (inst.i_fmt.funct3 == 3'b000) begin
                    uop_d.op = alu_jalr;
                end
            end
            op_lui: begin
                uop_d.op  = alu_pass_b;
                uop_d.b   = imm_u;
                uop_d.imm = imm_u;
            end
            op_auipc: begin
                // finished here, alu only passes it on
                uop_d.op  = alu_pass_b;
                uop_d.b   = issue_i.pc + imm_u;
                uop_d.imm = imm_u;
            end
            default: begin
                uop_d.op = alu_none;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        uop_o <= uop_d;
        if (reset_i) begin
            uop_o.valid <= 1'b0;
            uop_o.op    <= alu_none;
        end
    end

    // an issued item shows up next cycle with a legal op
    a_valid_op: assert property (
        @(posedge clk) disable iff (reset_i)
        issue_i.valid |=> uop_o.valid && !$isunknown(uop_o.op) && (uop_o.op <= alu_none)
    );

endmodule

`default_nettype wire

//--- rtl/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int xlen = 32;

    // shift amount field width for rv32
    localparam int shamt_w = 5;

    typedef logic [4:0] reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // funct3 for op_imm and op_reg
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // same instruction word, two field layouts
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } rv_inst_u;

    // alu_none stays last, range checks rely on it
    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_pass_b,
        alu_beq,
        alu_bne,
        alu_blt,
        alu_bge,
        alu_bltu,
        alu_bgeu,
        alu_jal,
        alu_jalr,
        alu_none
    } alu_op_e;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        rv_inst_u inst;
        word_t    rs1_data;
        word_t    rs2_data;
    } ex_issue_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        reg_addr_t rd;
        word_t     a;
        word_t     b;
        word_t     pc;
        word_t     imm;
    } ex_uop_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } ex_wb_t;

    typedef struct packed {
        logic  flag;
        word_t addr;
    } ex_jump_t;

endpackage

`default_nettype wire
